/* filelist.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_decoder.sv
source/sequencer.sv
source/control_encoder.sv
source/control_unit.sv
sim/control_unit_chk.sv
sim/tb_control_unit.sv

/* sim/control_unit_chk.sv */
`timescale 1ns/1ps

module control_unit_chk
    import ctrl_pkg::*;
(
    input logic  CLK,
    input logic  RST,
    input ctrl_t ctrl
);

    int fail_cnt = 0;   // read by the testbench at the end

    a_fetch_pc: assert property (@(posedge CLK) disable iff (RST)
        ctrl.ir_load |-> ctrl.pc_write)
    else begin
        $error("ir_load without pc_write");
        fail_cnt++;
    end

    a_rf_mem: assert property (@(posedge CLK) disable iff (RST)
        !(ctrl.rf_write && ctrl.mem_write))
    else begin
        $error("rf_write and mem_write high together");
        fail_cnt++;
    end

    // operand registers always load as a pair
    a_ab_load: assert property (@(posedge CLK) disable iff (RST)
        ctrl.a_load == ctrl.b_load)
    else begin
        $error("a_load differs from b_load");
        fail_cnt++;
    end

    a_dp_reset: assert property (@(posedge CLK) disable iff (RST)
        ctrl.dp_reset |-> $past(RST))
    else begin
        $error("dp_reset high later than the first cycle after reset");
        fail_cnt++;
    end

endmodule

bind control_unit control_unit_chk i_control_unit_chk (
    .CLK  (CLK),
    .RST  (RST),
    .ctrl (ctrl)
);

/* sim/tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_INSTR   = 400;
    localparam int HALT_CYCLES = 6;
    localparam int MAX_CYCLES  = NUM_INSTR * 7 + NUM_INSTR + 100;   // breaks add halt and reset

    logic        CLK;
    logic        RST;
    instr_word_t instr;
    alu_flags_t  flags;
    ctrl_t       ctrl;

    logic [31:0] lfsr = 32'h52ce_2a66;
    state_e      m_state;
    state_e      m_next;
    dec_t        cur;   // what the presented instruction should decode to
    alu_flags_t  cur_flags;
    int          reset_left = 3;
    int          halt_cycles = 0;
    int          n_instr = 0;
    int          errors = 0;
    int          since_fetch = 0;
    bit          seen_fetch = 1'b0;

    funct3_t  load_f3 [7] = '{F3_B, F3_H, F3_W, F3_D, F3_BU, F3_HU, F3_WU};
    wb_sel_e  load_wb [7] = '{wb_lb, wb_lh, wb_lw, wb_ld, wb_lbu, wb_lhu, wb_lwu};
    funct3_t  store_f3 [4] = '{F3_D, F3_W, F3_H, F3_B};   // st_d, st_w, st_h, st_b
    funct3_t  branch_f3 [4] = '{F3_BEQ, F3_BNE, F3_BGE, F3_BLT};   // eq, ne, ge, lt

    control_unit i_control_unit (
        .CLK   (CLK),
        .RST   (RST),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic new_instr();
        instr_word_t w;
        logic [31:0] r;
        logic [3:0]  kind;
        logic [1:0]  sel;
        r    = lfsr_bits(25);
        w    = r << 7;   // random registers and immediate
        r    = lfsr_bits(4);
        kind = r[3:0];
        r    = lfsr_bits(2);
        sel  = r[1:0];
        cur  = DEC_NOP;
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin   // add sub and slt
                w[6:0]     = OP_REG;
                w[31:25]   = (kind == 4'd1) ? F7_SUB : 7'b0;
                w[14:12]   = (kind == 4'd2) ? F3_AND : ((kind == 4'd3) ? F3_SLT : F3_ADD);
                cur.cls    = (kind == 4'd3) ? cls_slt : cls_alu;
                cur.alu_op = (kind == 4'd0) ? alu_add : ((kind == 4'd1) ? alu_sub : alu_and);
                if (kind == 4'd3) begin
                    cur.alu_op = alu_slt;
                end
            end
            4'd4, 4'd5: begin   // addi slti
                w[6:0]      = OP_IMM;
                w[14:12]    = (kind == 4'd4) ? F3_ADD : F3_SLT;
                cur.cls     = (kind == 4'd4) ? cls_alu : cls_slt;
                cur.alu_op  = (kind == 4'd4) ? alu_add : alu_slt;
                cur.use_imm = 1'b1;
            end
            4'd6, 4'd7: begin
                r           = lfsr_bits(3);
                w[6:0]      = OP_LOAD;
                w[14:12]    = 3'b111;   // unknown size unless picked below
                cur.cls     = cls_load;
                cur.alu_op  = alu_add;
                cur.use_imm = 1'b1;
                if (r[2:0] != 3'd7) begin
                    w[14:12]   = load_f3[r[2:0]];
                    cur.wb_sel = load_wb[r[2:0]];
                end else begin
                    cur = DEC_NOP;
                end
            end
            4'd8, 4'd9: begin
                w[6:0]         = OP_STORE;
                w[14:12]       = store_f3[sel];
                cur.cls        = cls_store;
                cur.alu_op     = alu_add;
                cur.use_imm    = 1'b1;
                cur.store_size = store_size_e'(sel);
            end
            4'd10, 4'd11: begin
                w[6:0]     = OP_BRANCH;
                w[14:12]   = branch_f3[sel];
                cur.cls    = cls_branch;
                cur.cond   = branch_cond_e'(sel);
                cur.alu_op = sel[1] ? alu_slt : alu_sub;
            end
            4'd12, 4'd13: begin   // lui jalr
                w[6:0]      = (kind == 4'd12) ? OP_LUI : OP_JALR;
                cur.cls     = (kind == 4'd12) ? cls_lui : cls_jalr;
                cur.alu_op  = alu_add;
                cur.use_imm = 1'b1;
                if (kind == 4'd13) begin
                    w[14:12] = F3_ADD;
                end
            end
            4'd14: w = {25'b0, OP_IMM};   // nop
            default: begin
                if (sel == 2'd0) begin
                    w[6:0]  = OP_SYSTEM;
                    cur.cls = cls_break;
                end else begin
                    r      = lfsr_bits(7);
                    w[6:0] = r[6:0];
                    if (w[6:0] inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH,
                                       OP_LUI, OP_JALR, OP_SYSTEM}) begin
                        w[6:0] = 7'b0001111;
                    end
                end
            end
        endcase
        if (w[6:0] == OP_IMM && w[31:7] == '0) begin
            cur = DEC_NOP;
        end
        instr <= w;
        n_instr++;
    endtask

    function automatic ctrl_t expected_ctrl(state_e s, dec_t d, alu_flags_t f);
        ctrl_t e;
        logic  taken;
        case (d.cond)
            cond_eq: taken = f.zero;
            cond_ne: taken = !f.zero;
            cond_lt: taken = f.less;
            default: taken = !f.less;
        endcase
        e = CTRL_IDLE;
        case (s)
            st_reset: e.dp_reset = 1'b1;
            st_fetch: begin
                e.ir_load  = 1'b1;
                e.pc_write = 1'b1;
                e.pc_src   = pc_alu_result;
                e.alu_op   = alu_add;
                e.src_a    = a_pc;
                e.src_b    = b_four;
            end
            st_decode: begin
                e.a_load       = 1'b1;
                e.b_load       = 1'b1;
                e.alu_out_load = 1'b1;
                e.alu_op       = alu_add;
                e.src_a        = a_pc;
                e.src_b        = b_imm_shifted;
            end
            st_execute: begin
                e.alu_op       = d.alu_op;
                e.src_a        = (d.cls == cls_lui) ? a_zero : a_rs1;
                e.src_b        = d.use_imm ? b_imm : b_rs2;
                e.alu_out_load = !(d.cls inside {cls_branch, cls_nop, cls_break});
                if (d.cls == cls_branch) begin
                    e.pc_write = taken;
                    e.pc_src   = pc_alu_out;
                end
            end
            st_wb_alu, st_wb_one, st_wb_zero: begin
                e.rf_write = 1'b1;
                e.wb_sel   = (s == st_wb_one) ? wb_one : ((s == st_wb_zero) ? wb_zero : wb_alu_out);
            end
            st_jalr_link: begin
                e.rf_write = 1'b1;
                e.wb_sel   = wb_pc;
                e.pc_write = 1'b1;
                e.pc_src   = pc_alu_out;
            end
            st_load_read, st_store_read: e.mdr_load = 1'b1;
            st_load_wb: begin
                e.rf_write = 1'b1;
                e.wb_sel   = d.wb_sel;
            end
            st_store_write: begin
                e.mem_write  = 1'b1;
                e.store_size = d.store_size;
            end
            default: e = CTRL_IDLE;
        endcase
        return e;
    endfunction

    function automatic state_e next_state_of(state_e s, dec_t d, alu_flags_t f);
        case (s)
            st_reset:  return st_wait;
            st_wait:   return st_fetch;
            st_fetch:  return st_decode;
            st_decode: return st_execute;
            st_execute: begin
                case (d.cls)
                    cls_alu, cls_lui: return st_wb_alu;
                    cls_slt:          return f.less ? st_wb_one : st_wb_zero;
                    cls_jalr:         return st_jalr_link;
                    cls_load:         return st_load_wait;
                    cls_store:        return st_store_read;
                    cls_break:        return st_halt;
                    default:          return st_wait;
                endcase
            end
            st_load_wait:  return st_load_read;
            st_load_read:  return st_load_wb;
            st_store_read: return st_store_wait;
            st_store_wait: return st_store_write;
            st_halt:       return st_halt;
            default:       return st_wait;
        endcase
    endfunction

    // cycles from one ir_load to the next
    function automatic int seq_len(instr_class_e c);
        case (c)
            cls_alu, cls_lui, cls_slt, cls_jalr: return 5;
            cls_load, cls_store:                 return 7;
            default:                             return 4;
        endcase
    endfunction

    task automatic check_cycle();
        ctrl_t exp_ctrl;
        exp_ctrl = expected_ctrl(m_state, cur, cur_flags);
        assert (ctrl === exp_ctrl)
        else begin
            errors++;
            $display("MISMATCH %s/%s: expected %h actual %h",
                     cur.cls.name(), m_state.name(), exp_ctrl, ctrl);
        end
        if (ctrl.ir_load) begin
            if (seen_fetch) begin
                assert (since_fetch == seq_len(cur.cls))
                else begin
                    errors++;
                    $display("MISMATCH %s/length: expected %0d actual %0d",
                             cur.cls.name(), seq_len(cur.cls), since_fetch);
                end
            end
            seen_fetch  = 1'b1;
            since_fetch = 0;
        end
        since_fetch++;
    endtask

    initial begin
        logic [31:0] r;
        RST       = 1'b1;
        instr     = '0;
        flags     = '0;
        m_state   = st_reset;
        m_next    = st_reset;
        cur       = DEC_NOP;
        cur_flags = '0;
        while (n_instr <= NUM_INSTR) begin
            @(posedge CLK);
            if (m_state == st_fetch) begin
                new_instr();   // ir holds it from this edge on
            end
            if (reset_left > 0) begin
                RST <= 1'b1;
                reset_left--;
                m_state    = st_reset;
                seen_fetch = 1'b0;
            end else begin
                m_state = RST ? st_reset : m_next;
                RST <= 1'b0;
            end
            r              = lfsr_bits(2);
            cur_flags.zero = r[1];
            cur_flags.less = r[0];
            flags <= cur_flags;
            @(negedge CLK);
            check_cycle();
            m_next = next_state_of(m_state, cur, cur_flags);
            if (m_state == st_halt) begin
                halt_cycles++;
                if (halt_cycles == HALT_CYCLES) begin
                    reset_left  = 3;   // only reset leaves halt
                    halt_cycles = 0;
                end
            end
        end
        $display("done: %0d instructions, %0d model errors, %0d assertion failures",
                 NUM_INSTR, errors, i_control_unit.i_control_unit_chk.fail_cnt);
        if (errors == 0 && i_control_unit.i_control_unit_chk.fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * MAX_CYCLES);
        $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* source/control_encoder.sv */
`timescale 1ns/1ps

module control_encoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  state_e     state,
    input  dec_t       dec,
    input  alu_flags_t flags,
    output ctrl_t      ctrl
);

    logic branch_taken;

    always_comb begin
        case (dec.cond)
            cond_eq: branch_taken = flags.zero;
            cond_ne: branch_taken = ~flags.zero;
            cond_lt: branch_taken = flags.less;
            default: branch_taken = ~flags.less;   // ge
        endcase
    end

    always_comb begin
        ctrl = CTRL_IDLE;
        case (state)
            st_reset: begin
                ctrl.dp_reset = 1'b1;
            end
            st_fetch: begin
                ctrl.ir_load  = 1'b1;
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = pc_alu_result;
                ctrl.alu_op   = alu_add;   // pc + 4
                ctrl.src_a    = a_pc;
                ctrl.src_b    = b_four;
            end
            st_decode: begin
                ctrl.a_load       = 1'b1;
                ctrl.b_load       = 1'b1;
                ctrl.alu_out_load = 1'b1;   // branch target kept in alu_out
                ctrl.alu_op       = alu_add;
                ctrl.src_a        = a_pc;
                ctrl.src_b        = b_imm_shifted;
            end
            st_execute: begin
                ctrl.alu_op = dec.alu_op;
                if (dec.cls == cls_lui) begin
                    ctrl.src_a = a_zero;
                end else begin
                    ctrl.src_a = a_rs1;
                end
                if (dec.use_imm) begin
                    ctrl.src_b = b_imm;
                end else begin
                    ctrl.src_b = b_rs2;
                end
                case (dec.cls)
                    cls_alu, cls_slt, cls_lui, cls_jalr, cls_load, cls_store: begin
                        ctrl.alu_out_load = 1'b1;
                    end
                    cls_branch: begin
                        ctrl.pc_write = branch_taken;
                        ctrl.pc_src   = pc_alu_out;
                    end
                    default: begin
                        ctrl.alu_out_load = 1'b0;
                    end
                endcase
            end
            st_wb_alu: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = wb_alu_out;
            end
            st_wb_one: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = wb_one;
            end
            st_wb_zero: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = wb_zero;
            end
            st_jalr_link: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = wb_pc;   // rd = return address
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = pc_alu_out;
            end
            st_load_read, st_store_read: begin
                ctrl.mdr_load = 1'b1;
            end
            st_load_wb: begin
                ctrl.rf_write = 1'b1;
                ctrl.wb_sel   = dec.wb_sel;   // size and sign of the load
            end
            st_store_write: begin
                ctrl.mem_write  = 1'b1;
                ctrl.store_size = dec.store_size;
            end
            default: begin
                ctrl = CTRL_IDLE;   // wait states and halt
            end
        endcase
    end

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        CLK,
    input  logic        RST,
    input  instr_word_t instr,
    input  alu_flags_t  flags,
    output ctrl_t       ctrl
);

    dec_t   dec;
    state_e state;

    instr_decoder i_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    sequencer i_sequencer (
        .CLK   (CLK),
        .RST   (RST),
        .cls   (dec.cls),
        .less  (flags.less),
        .state (state)
    );

    control_encoder i_control_encoder (
        .state (state),
        .dec   (dec),
        .flags (flags),
        .ctrl  (ctrl)
    );

endmodule

/* source/ctrl_pkg.sv */
package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        st_reset, st_wait, st_fetch, st_decode, st_execute,
        st_wb_alu, st_wb_one, st_wb_zero, st_jalr_link,
        st_load_wait, st_load_read, st_load_wb,
        st_store_read, st_store_wait, st_store_write,
        st_halt
    } state_e;

    typedef enum logic [2:0] {
        alu_none = 3'b000,
        alu_add  = 3'b001,
        alu_sub  = 3'b010,
        alu_and  = 3'b011,
        alu_sge  = 3'b101,
        alu_slt  = 3'b110
    } alu_op_e;

    typedef enum logic [1:0] {
        a_pc   = 2'b00,
        a_rs1  = 2'b01,
        a_zero = 2'b11
    } src_a_e;

    typedef enum logic [1:0] {b_rs2, b_four, b_imm, b_imm_shifted} src_b_e;

    typedef enum logic {
        pc_alu_out    = 1'b0,   // registered target
        pc_alu_result = 1'b1    // pc + 4 straight from the ALU
    } pc_src_e;

    // load codes match the datapath extend mux
    typedef enum logic [3:0] {
        wb_alu_out = 4'b0000,
        wb_one     = 4'b0010,
        wb_zero    = 4'b0011,
        wb_pc      = 4'b0100,
        wb_ld      = 4'b0101,
        wb_lb      = 4'b0110,
        wb_lh      = 4'b0111,
        wb_lw      = 4'b1000,
        wb_lbu     = 4'b1001,
        wb_lhu     = 4'b1010,
        wb_lwu     = 4'b1011
    } wb_sel_e;

    typedef enum logic [1:0] {st_d, st_w, st_h, st_b} store_size_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        logic         use_imm;
        wb_sel_e      wb_sel;
        store_size_e  store_size;
        branch_cond_e cond;
    } dec_t;

    typedef struct packed {
        logic zero;
        logic less;
    } alu_flags_t;

    typedef struct packed {
        logic        dp_reset;
        logic        pc_write;
        logic        ir_load;
        logic        a_load;
        logic        b_load;
        logic        alu_out_load;
        logic        mdr_load;
        logic        rf_write;
        logic        mem_write;
        alu_op_e     alu_op;
        src_a_e      src_a;
        src_b_e      src_b;
        pc_src_e     pc_src;
        wb_sel_e     wb_sel;
        store_size_e store_size;
    } ctrl_t;

    localparam dec_t DEC_NOP = '{cls: cls_nop, alu_op: alu_none, use_imm: 1'b0,
                                 wb_sel: wb_alu_out, store_size: st_d, cond: cond_eq};

    localparam ctrl_t CTRL_IDLE = '{alu_op: alu_none, src_a: a_pc, src_b: b_rs2,
                                    pc_src: pc_alu_result, wb_sel: wb_alu_out,
                                    store_size: st_d, default: 1'b0};

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  instr_word_t instr,
    output dec_t        dec
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = instr[OPCODE_W-1:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec = DEC_NOP;   // unknown encodings fall through as nop
        case (opcode)
            OP_REG: begin
                dec.cls    = cls_alu;
                dec.alu_op = alu_add;
                if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    dec.alu_op = alu_sub;
                end else if (funct3 == F3_AND && funct7 == '0) begin
                    dec.alu_op = alu_and;
                end else if (funct3 == F3_SLT && funct7 == '0) begin
                    dec.cls    = cls_slt;
                    dec.alu_op = alu_slt;
                end else if (funct3 != F3_ADD || funct7 != '0) begin
                    dec = DEC_NOP;
                end
            end
            OP_IMM: begin
                dec.use_imm = 1'b1;
                if (instr[31:7] == '0) begin
                    dec = DEC_NOP;   // addi x0, x0, 0
                end else if (funct3 == F3_ADD) begin
                    dec.cls    = cls_alu;
                    dec.alu_op = alu_add;
                end else if (funct3 == F3_SLT) begin
                    dec.cls    = cls_slt;
                    dec.alu_op = alu_slt;
                end else begin
                    dec = DEC_NOP;
                end
            end
            OP_LOAD: begin
                dec.cls     = cls_load;
                dec.alu_op  = alu_add;   // address = rs1 + imm
                dec.use_imm = 1'b1;
                case (funct3)
                    F3_D:    dec.wb_sel = wb_ld;
                    F3_B:    dec.wb_sel = wb_lb;
                    F3_H:    dec.wb_sel = wb_lh;
                    F3_W:    dec.wb_sel = wb_lw;
                    F3_BU:   dec.wb_sel = wb_lbu;
                    F3_HU:   dec.wb_sel = wb_lhu;
                    F3_WU:   dec.wb_sel = wb_lwu;
                    default: dec = DEC_NOP;
                endcase
            end
            OP_STORE: begin
                dec.cls     = cls_store;
                dec.alu_op  = alu_add;
                dec.use_imm = 1'b1;
                case (funct3)
                    F3_D:    dec.store_size = st_d;
                    F3_W:    dec.store_size = st_w;
                    F3_H:    dec.store_size = st_h;
                    F3_B:    dec.store_size = st_b;
                    default: dec = DEC_NOP;
                endcase
            end
            OP_BRANCH: begin
                dec.cls = cls_branch;
                case (funct3)
                    F3_BEQ: begin
                        dec.cond   = cond_eq;
                        dec.alu_op = alu_sub;
                    end
                    F3_BNE: begin
                        dec.cond   = cond_ne;
                        dec.alu_op = alu_sub;
                    end
                    F3_BLT: begin
                        dec.cond   = cond_lt;
                        dec.alu_op = alu_slt;
                    end
                    F3_BGE: begin
                        dec.cond   = cond_ge;
                        dec.alu_op = alu_slt;
                    end
                    default: dec = DEC_NOP;
                endcase
            end
            OP_LUI: begin
                dec.cls     = cls_lui;
                dec.alu_op  = alu_add;   // 0 + upper immediate
                dec.use_imm = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == F3_ADD) begin
                    dec.cls     = cls_jalr;
                    dec.alu_op  = alu_add;
                    dec.use_imm = 1'b1;
                end
            end
            OP_SYSTEM: dec.cls = cls_break;
            default: dec = DEC_NOP;
        endcase
    end

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    typedef logic [INSTR_W-1:0]  instr_word_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;   // break

    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_AND = 3'b111;

    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // load and store sizes
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_D  = 3'b011;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;
    localparam funct3_t F3_WU = 3'b110;

    localparam funct7_t F7_SUB = 7'b0100000;

    typedef enum logic [3:0] {
        cls_alu, cls_slt, cls_load, cls_store, cls_branch,
        cls_lui, cls_jalr, cls_nop, cls_break
    } instr_class_e;

    typedef enum logic [1:0] {cond_eq, cond_ne, cond_ge, cond_lt} branch_cond_e;

endpackage

/* source/sequencer.sv */
`timescale 1ns/1ps

module sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         CLK,
    input  logic         RST,
    input  instr_class_e cls,
    input  logic         less,
    output state_e       state
);

    state_e next_state;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_wait;
        case (state)
            st_reset:  next_state = st_wait;
            st_wait:   next_state = st_fetch;
            st_fetch:  next_state = st_decode;
            st_decode: next_state = st_execute;

            st_execute: begin
                case (cls)
                    cls_alu, cls_lui: begin
                        next_state = st_wb_alu;
                    end
                    cls_slt: begin
                        // less is valid here, the ALU runs slt this cycle
                        if (less) begin
                            next_state = st_wb_one;
                        end else begin
                            next_state = st_wb_zero;
                        end
                    end
                    cls_jalr:  next_state = st_jalr_link;
                    cls_load:  next_state = st_load_wait;
                    cls_store: next_state = st_store_read;
                    cls_break: next_state = st_halt;
                    default:   next_state = st_wait;   // branch, nop
                endcase
            end

            // single write-back cycles
            st_wb_alu:    next_state = st_wait;
            st_wb_one:    next_state = st_wait;
            st_wb_zero:   next_state = st_wait;
            st_jalr_link: next_state = st_wait;

            // load path
            st_load_wait: next_state = st_load_read;
            st_load_read: next_state = st_load_wb;
            st_load_wb:   next_state = st_wait;

            // store path, read first for partial writes
            st_store_read:  next_state = st_store_wait;
            st_store_wait:  next_state = st_store_write;
            st_store_write: next_state = st_wait;

            st_halt: next_state = st_halt;   // until reset
            default: next_state = st_reset;
        endcase
    end

endmodule
